// File: project.f
verilog/branch_pkg.sv
verilog/ram_sdp.sv
verilog/delay_line.sv
verilog/control_memory.sv
verilog/condition_evaluator.sv
verilog/branch_resolver.sv
verilog/branch_unit.sv
verif/branch_unit_tb.sv

// File: verif/branch_unit_tb.sv
// Self-checking testbench for the branch detection stage; compile with project.f, top branch_unit_tb.
`timescale 1ns/100ps
`default_nettype none

module branch_unit_tb;

    localparam int THREADS     = 8;
    localparam int LATENCY     = 5;  // Cycles from driving a request to sampling its result.
    localparam int DRAIN_LIMIT = 50;

    logic                       clock;
    logic                       rst_n;
    branch_pkg::branch_req_t    req;
    branch_pkg::alu_flags_t     flags;
    branch_pkg::entry_write_t   wr;
    branch_pkg::branch_result_t result;

    branch_pkg::alu_flags_t     flag_pipe0; // Flags still two edges from the DUT.
    branch_pkg::alu_flags_t     flag_pipe1;
    branch_pkg::branch_entry_t  shadow [THREADS];
    branch_pkg::branch_result_t expect_q [$];
    int                         due_q [$];   // Cycle each expected result must appear.
    int                         cycle;
    int                         errors;
    int                         tests_run;
    int                         tests_failed;
    int                         test_start;
    integer                     seed;
    int                         i;
    int                         t;
    branch_pkg::branch_entry_t  e;
    logic [branch_pkg::PC_WIDTH-1:0] pc;

    branch_unit #(
        .THREADS (THREADS)
    ) u_dut (
        .clock  (clock),
        .rst_n  (rst_n),
        .req    (req),
        .flags  (flags),
        .wr     (wr),
        .result (result)
    );

    always #4 clock = ~clock;

    // The ALU completes a thread's instruction two cycles after its request.
    always @(posedge clock) begin
        flag_pipe1 <= flag_pipe0;
        flags      <= flag_pipe1;
    end

    function automatic branch_pkg::branch_result_t expected_result(
        input branch_pkg::branch_entry_t                entry,
        input logic [branch_pkg::PC_WIDTH-1:0]         req_pc,
        input branch_pkg::alu_flags_t                   f,
        input logic [branch_pkg::THREAD_WIDTH-1:0]     thread
    );
        branch_pkg::branch_result_t r;
        logic holds;
        case (entry.cond)
            branch_pkg::COND_NEVER:        holds = 1'b0;
            branch_pkg::COND_ALWAYS:       holds = 1'b1;
            branch_pkg::COND_ZERO:         holds = f.zero;
            branch_pkg::COND_NOT_ZERO:     holds = !f.zero;
            branch_pkg::COND_NEGATIVE:     holds = f.negative;
            branch_pkg::COND_NOT_NEGATIVE: holds = !f.negative;
            branch_pkg::COND_CARRY:        holds = f.carry;
            branch_pkg::COND_OVERFLOW:     holds = f.overflow;
            default:                       holds = 1'b0;
        endcase
        r.valid  = 1'b1;
        r.thread = thread;
        r.taken  = (req_pc == entry.match_pc) && holds;
        r.target = r.taken ? entry.link : '0;
        return r;
    endfunction

    function automatic branch_pkg::alu_flags_t random_flags();
        return branch_pkg::alu_flags_t'($random(seed));
    endfunction

    task automatic check_result(input branch_pkg::branch_result_t got,
                                input branch_pkg::branch_result_t want);
        if (got !== want) begin
            $display("FAIL %0t: thread %0d taken %0b target %0h, expected %0d %0b %0h",
                     $time, got.thread, got.taken, got.target,
                     want.thread, want.taken, want.target);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int want);
        if (got != want) begin
            $display("FAIL %0t: result in cycle %0d, expected in cycle %0d", $time, got, want);
            errors++;
        end
    endtask

    // Results are sampled half a cycle after the DUT updates them.
    always @(negedge clock) begin
        if (rst_n && result.valid) begin
            if (expect_q.size() == 0) begin
                $display("Unexpected result at %0t: thread %0d arrived with no request pending.",
                         $time, result.thread);
                errors++;
            end else begin
                check_result(result, expect_q.pop_front());
                check_latency(cycle, due_q.pop_front());
            end
        end
        cycle <= cycle + 1;
    end

    task automatic issue(input int thread, input logic [branch_pkg::PC_WIDTH-1:0] req_pc,
                         input branch_pkg::alu_flags_t f);
        branch_pkg::branch_req_t r;
        r.valid  = 1'b1;
        r.thread = thread[branch_pkg::THREAD_WIDTH-1:0];
        r.pc     = req_pc;
        @(posedge clock);
        req        <= r;
        flag_pipe0 <= f;
        expect_q.push_back(expected_result(shadow[thread], req_pc, f, r.thread));
        due_q.push_back(cycle + LATENCY);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            req        <= '0;
            flag_pipe0 <= '0;
        end
    endtask

    task automatic write_entry(input int thread, input branch_pkg::branch_entry_t entry);
        branch_pkg::entry_write_t w;
        w.wren   = 1'b1;
        w.thread = thread[branch_pkg::THREAD_WIDTH-1:0];
        w.entry  = entry;
        @(posedge clock);
        wr  <= w;
        req <= '0;
        @(posedge clock);
        wr.wren <= 1'b0;
        shadow[thread] = entry;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (expect_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clock);
            n++;
        end
        if (expect_q.size() != 0) begin
            $display("Timeout at %0t: %0d results never arrived.", $time, expect_q.size());
            errors++;
            expect_q.delete();
            due_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_start) begin
            tests_failed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: passed", name);
        end
        test_start = errors;
    endtask

    initial begin
        seed       = 32'hc3206f7a;
        clock      = 1'b0;
        rst_n      = 1'b0;
        req        = '0;
        flags      = '0;
        wr         = '0;
        flag_pipe0 = '0;
        flag_pipe1 = '0;
        cycle      = 0;
        errors     = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start   = 0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        for (i = 0; i < 20; i++) begin
            @(negedge clock);
            if (result.valid !== 1'b0) begin
                $display("FAIL %0t: result.valid high with no request issued", $time);
                errors++;
            end
        end
        end_test("idle after reset");

        for (i = 0; i < THREADS; i++) begin
            e.match_pc = 10'(16 * i + 3);
            e.cond     = branch_pkg::COND_ALWAYS;
            e.link     = 10'(200 + 7 * i);
            write_entry(i, e);
        end
        for (i = 0; i < THREADS; i++) begin
            issue(i, shadow[i].match_pc, random_flags());
        end
        idle_cycles(1);
        wait_drain();
        end_test("taken on PC match");

        for (i = 0; i < THREADS; i++) begin
            issue(i, shadow[i].match_pc ^ 10'h001, random_flags()); // Off by one bit.
        end
        idle_cycles(1);
        wait_drain();
        end_test("not taken on PC mismatch");

        // Thread index picks the opcode, so all eight are used.
        for (i = 0; i < THREADS; i++) begin
            e.match_pc = 10'($random(seed));
            e.cond     = branch_pkg::cond_op_t'(i % 8);
            e.link     = 10'($random(seed));
            write_entry(i, e);
        end
        for (i = 0; i < 300; i++) begin
            t = $unsigned($random(seed)) % THREADS;
            if ($random(seed) & 1) begin
                pc = shadow[t].match_pc;
            end else begin
                pc = 10'($random(seed));
            end
            issue(t, pc, random_flags());
        end
        idle_cycles(1);
        wait_drain();
        end_test("random back-to-back requests");

        idle_cycles(4);
        for (i = 0; i < THREADS; i++) begin
            e      = shadow[i];
            e.cond = (i % 2 == 0) ? branch_pkg::COND_NEVER : branch_pkg::COND_ALWAYS;
            e.link = ~e.link;
            write_entry(i, e);
        end
        for (i = 0; i < 2 * THREADS; i++) begin
            issue(i % THREADS, shadow[i % THREADS].match_pc, random_flags());
        end
        idle_cycles(1);
        wait_drain();
        end_test("rewritten entries");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/branch_pkg.sv
// Shared types and constants for the branch detection stage; compile this before any module.
`default_nettype none

package branch_pkg;

    localparam int PC_WIDTH     = 10; // Program counters and link targets.
    localparam int THREAD_WIDTH = 8;  // Wide enough for the largest thread count.

    // Branch condition opcodes, stored in each entry.
    typedef enum logic [2:0] {
        COND_NEVER        = 3'd0,
        COND_ALWAYS       = 3'd1,
        COND_ZERO         = 3'd2,
        COND_NOT_ZERO     = 3'd3,
        COND_NEGATIVE     = 3'd4,
        COND_NOT_NEGATIVE = 3'd5,
        COND_CARRY        = 3'd6,
        COND_OVERFLOW     = 3'd7
    } cond_op_t;

    // One branch entry per thread. This is the RAM word.
    typedef struct packed {
        logic [PC_WIDTH-1:0] match_pc; // PC that triggers the branch.
        cond_op_t            cond;
        logic [PC_WIDTH-1:0] link;     // Branch target.
    } branch_entry_t;

    typedef struct packed {
        logic zero;
        logic negative;
        logic carry;
        logic overflow;
    } alu_flags_t;

    typedef struct packed {
        logic                    valid;
        logic [THREAD_WIDTH-1:0] thread;
        logic [PC_WIDTH-1:0]     pc;
    } branch_req_t;

    // Software write port into the entry store.
    typedef struct packed {
        logic                    wren;
        logic [THREAD_WIDTH-1:0] thread;
        branch_entry_t           entry;
    } entry_write_t;

    typedef struct packed {
        logic                    valid;
        logic [THREAD_WIDTH-1:0] thread;
        logic                    taken;
        logic [PC_WIDTH-1:0]     target; // Zero when not taken.
    } branch_result_t;

endpackage

`default_nettype wire

// File: verilog/branch_resolver.sv
// Matches the request PC, aligns it with the condition outcome and link, and emits the result.
`timescale 1ns/100ps
`default_nettype none

module branch_resolver (
    input  wire                               clock,
    input  wire                               rst_n,
    input  wire  branch_pkg::branch_req_t     req,
    input  wire  [branch_pkg::PC_WIDTH-1:0]   match_pc,
    input  wire                               cond_true,
    input  wire  [branch_pkg::PC_WIDTH-1:0]   link,
    output branch_pkg::branch_result_t        result
);

    localparam int TAG_WIDTH = 1 + branch_pkg::THREAD_WIDTH;

    logic [branch_pkg::PC_WIDTH-1:0]     pc_q;        // Request PC at t+1.
    logic                                hit_d;       // PC match at t+4.
    logic                                cond_true_d; // Condition outcome at t+4.
    logic                                valid_d;
    logic [branch_pkg::THREAD_WIDTH-1:0] thread_d;
    logic                                taken;

    always_ff @(posedge clock) begin
        pc_q <= req.pc;
    end

    // Valid and thread ride alongside the item until the result stage.
    delay_line #(
        .DEPTH (4),
        .WIDTH (TAG_WIDTH)
    ) u_tag_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    ({req.valid, req.thread}),
        .out   ({valid_d, thread_d})
    );

    delay_line #(
        .DEPTH (3),
        .WIDTH (1)
    ) u_hit_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (pc_q == match_pc), // First stage registers the hit at t+2.
        .out   (hit_d)
    );

    delay_line #(
        .DEPTH (1),
        .WIDTH (1)
    ) u_cond_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (cond_true),
        .out   (cond_true_d)
    );

    // Empty slots reach this stage with a false condition.
    assign taken = hit_d & cond_true_d;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid  <= valid_d;
            result.thread <= thread_d;
            result.taken  <= taken;
            result.target <= taken ? link : '0; // Seen at t+5.
        end
    end

    a_taken_valid: assert property (
        @(posedge clock) disable iff (!rst_n) result.taken |-> result.valid
    ) else $error("Branch taken on an invalid result.");

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
// Top level of the branch detection stage; connects request, flag and entry write ports.
`timescale 1ns/100ps
`default_nettype none

module branch_unit #(
    parameter int  THREADS    = 8,
    localparam int ADDR_WIDTH = (THREADS > 1) ? $clog2(THREADS) : 1
) (
    input  wire                              clock,
    input  wire                              rst_n,
    input  wire  branch_pkg::branch_req_t    req,
    input  wire  branch_pkg::alu_flags_t     flags,
    input  wire  branch_pkg::entry_write_t   wr,
    output wire  branch_pkg::branch_result_t result
);

    logic [branch_pkg::PC_WIDTH-1:0] match_pc;  // Entry PC at t+1.
    branch_pkg::cond_op_t            cond;      // Entry condition at t+2.
    logic [branch_pkg::PC_WIDTH-1:0] link;      // Entry target at t+4.
    logic                            cond_true; // Condition outcome at t+3.

    // Entry lookup for the issuing thread.
    control_memory #(
        .THREADS (THREADS)
    ) u_control_memory (
        .clock       (clock),
        .rst_n       (rst_n),
        .wr          (wr),
        .read_valid  (req.valid),
        .read_thread (req.thread[ADDR_WIDTH-1:0]),
        .match_pc    (match_pc),
        .cond        (cond),
        .link        (link)
    );

    // Flags arrive two cycles after the request.
    condition_evaluator u_condition_evaluator (
        .clock     (clock),
        .rst_n     (rst_n),
        .cond      (cond),
        .flags     (flags),
        .cond_true (cond_true)
    );

    branch_resolver u_branch_resolver (
        .clock     (clock),
        .rst_n     (rst_n),
        .req       (req),
        .match_pc  (match_pc),
        .cond_true (cond_true),
        .link      (link),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: verilog/condition_evaluator.sv
// Evaluates a branch condition opcode against the ALU flags and registers the outcome.
`timescale 1ns/100ps
`default_nettype none

module condition_evaluator (
    input  wire                        clock,
    input  wire                        rst_n,
    input  wire  branch_pkg::cond_op_t cond,
    input  wire  branch_pkg::alu_flags_t flags,
    output logic                       cond_true
);

    logic cond_hold; // Combinational outcome at t+2.

    always_comb begin
        case (cond)
            branch_pkg::COND_NEVER: begin
                cond_hold = 1'b0;
            end
            branch_pkg::COND_ALWAYS: begin
                cond_hold = 1'b1;
            end
            branch_pkg::COND_ZERO: begin
                cond_hold = flags.zero;
            end
            branch_pkg::COND_NOT_ZERO: begin
                cond_hold = ~flags.zero;
            end
            branch_pkg::COND_NEGATIVE: begin
                cond_hold = flags.negative;
            end
            branch_pkg::COND_NOT_NEGATIVE: begin
                cond_hold = ~flags.negative;
            end
            branch_pkg::COND_CARRY: begin
                cond_hold = flags.carry;
            end
            branch_pkg::COND_OVERFLOW: begin
                cond_hold = flags.overflow;
            end
            default: begin
                cond_hold = 1'b0; // Unknown opcode never branches.
            end
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cond_true <= 1'b0;
        end else begin
            cond_true <= cond_hold; // Ready at t+3.
        end
    end

    // The control memory substitutes NEVER for empty slots, so any X is a bad entry.
    a_cond_known: assert property (
        @(posedge clock) disable iff (!rst_n) !$isunknown(cond)
    ) else $error("Condition opcode is unknown.");

endmodule

`default_nettype wire

// File: verilog/control_memory.sv
// Per-thread branch entry store; presents match PC, condition and link at their pipeline stages.
`timescale 1ns/100ps
`default_nettype none

module control_memory #(
    parameter int  THREADS    = 8,
    localparam int ADDR_WIDTH = (THREADS > 1) ? $clog2(THREADS) : 1
) (
    input  wire                                clock,
    input  wire                                rst_n,
    input  wire  branch_pkg::entry_write_t     wr,
    input  wire                                read_valid,
    input  wire  [ADDR_WIDTH-1:0]              read_thread,
    output logic [branch_pkg::PC_WIDTH-1:0]    match_pc,
    output branch_pkg::cond_op_t               cond,
    output logic [branch_pkg::PC_WIDTH-1:0]    link
);

    localparam int COND_WIDTH = $bits(branch_pkg::cond_op_t);

    branch_pkg::branch_entry_t word;       // RAM output, one cycle after the read.
    logic                      word_valid; // Read valid, aligned with word.
    branch_pkg::cond_op_t      cond_in;
    logic [COND_WIDTH-1:0]     cond_q;

    ram_sdp #(
        .WIDTH   ($bits(branch_pkg::branch_entry_t)),
        .THREADS (THREADS)
    ) u_ram (
        .clock      (clock),
        .wren       (wr.wren),
        .write_addr (wr.thread[ADDR_WIDTH-1:0]),
        .write_data (wr.entry),
        .read_addr  (read_thread),
        .read_data  (word)
    );

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= read_valid;
        end
    end

    assign match_pc = word.match_pc; // Used at t+1.

    // Empty slots carry NEVER so the evaluator always sees a known opcode.
    assign cond_in = word_valid ? word.cond : branch_pkg::COND_NEVER;

    delay_line #(
        .DEPTH (1),
        .WIDTH (COND_WIDTH)
    ) u_cond_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (cond_in),
        .out   (cond_q)
    );

    assign cond = branch_pkg::cond_op_t'(cond_q); // Used at t+2.

    // Link is needed last, at t+4.
    delay_line #(
        .DEPTH (3),
        .WIDTH (branch_pkg::PC_WIDTH)
    ) u_link_delay (
        .clock (clock),
        .rst_n (rst_n),
        .in    (word.link),
        .out   (link)
    );

    // The RAM has no forwarding, so a colliding write leaves the read undefined.
    a_no_rw_collision: assert property (
        @(posedge clock) disable iff (!rst_n)
        (wr.wren && read_valid) |-> (wr.thread[ADDR_WIDTH-1:0] != read_thread)
    ) else $error("Entry write collides with a read of the same thread.");

endmodule

`default_nettype wire

// File: verilog/delay_line.sv
// Register chain that delays a vector by DEPTH clock cycles; used to align pipeline fields.
`timescale 1ns/100ps
`default_nettype none

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  wire              clock,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] in,
    output logic [WIDTH-1:0] out
);

    logic [WIDTH-1:0] stage [DEPTH];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1]; // Shift one step.
            end
        end
    end

    assign out = stage[DEPTH-1];

endmodule

`default_nettype wire

// File: verilog/ram_sdp.sv
// Simple dual-port RAM holding one word per thread, with a registered read and no forwarding.
`timescale 1ns/100ps
`default_nettype none

module ram_sdp #(
    parameter int  WIDTH      = 23,
    parameter int  THREADS    = 8,
    localparam int ADDR_WIDTH = (THREADS > 1) ? $clog2(THREADS) : 1
) (
    input  wire                   clock,
    input  wire                   wren,
    input  wire  [ADDR_WIDTH-1:0] write_addr,
    input  wire  [WIDTH-1:0]      write_data,
    input  wire  [ADDR_WIDTH-1:0] read_addr,
    output logic [WIDTH-1:0]      read_data
);

    logic [WIDTH-1:0] mem [THREADS];

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
        // Same-address write and read return the old word.
        read_data <= mem[read_addr];
    end

    // Non power of two thread counts leave unused addresses.
    a_write_addr_range: assert property (
        @(posedge clock) wren |-> (write_addr < THREADS)
    ) else $error("RAM write address out of range.");

    a_read_addr_range: assert property (
        @(posedge clock) !$isunknown(read_addr) |-> (read_addr < THREADS)
    ) else $error("RAM read address out of range.");

endmodule

`default_nettype wire
